/* sim/dbg_patterns.txt */
# s XX send byte, e XX expect tx byte, w AAAA DD expect write
# a B expect active once tx drains, b pulse brk
a 0
s 07
e 00
s 03
a 1
s 07
e 01
s 08
e 00
s 04
a 0
b
a 1
# ECHO 3 bytes
s 00
s 03
s 00
s a5
s 5a
s 3c
e a5
e 5a
e 3c
# ECHO 0 bytes then a query
s 00
s 00
s 00
s 07
e 01
# CPU_MEM_WR 3 bytes at 12fe
s 02
s fe
s 12
s 03
s 00
s 11
s 22
s 33
w 12fe 11
w 12ff 22
w 1300 33
# CPU_MEM_RD 5 bytes from 12fd
s 01
s fd
s 12
s 05
s 00
e ef
e 11
e 22
e 33
e 12
# Unknown opcode, error bit stays set
s 05
s 08
e 02
s 07
e 01
s 08
e 02

/* src.f */
hdl/dbg_proto_pkg.sv
hdl/dbg_bus_pkg.sv
hdl/dbg_ifs.sv
hdl/dbg_xfer_cnt.sv
hdl/dbg_cpu_port.sv
hdl/dbg_tx_buf.sv
hdl/dbg_ctrl.sv
hdl/dbg_top.sv
sim/dbg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debug packet engine testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module dbg_tb -o dbg_tb_sim &&
./obj_dir/dbg_tb_sim | tee /dev/stderr | grep -q "^Verification passed$" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

/* sim/dbg_tb.sv */
/*
  Self-checking testbench for dbg_top, run from the project root.
  Pattern lines come from sim/dbg_patterns.txt. Model memory byte at
  A starts as A[7:0] ^ A[15:8] and follows the DUT write strobes.
  Host gaps and tx back-pressure come from $random with a fixed seed.
*/
`timescale 1ns/1ps

module dbg_tb;
  import dbg_proto_pkg::*;
  import dbg_bus_pkg::*;

  logic   clk;
  logic   rst;
  byte_t  rx_data;
  logic   rx_valid;
  logic   rx_ready;
  byte_t  tx_data;
  logic   tx_valid;
  logic   tx_ready;
  logic   brk;
  logic   active;
  addr_t  cpu_a;
  logic   cpu_r_nw;
  byte_t  cpu_dout;
  byte_t  cpu_din;

  byte_t  mem [0:65535];       // CPU memory model
  integer seed = 32'h154c;
  logic   hold_off;            // Host idles this cycle
  int     n_lines = 0;

  // Pattern lines, kind and up to two values
  byte_t  kind_q [$];
  addr_t  arg1_q [$];
  byte_t  arg2_q [$];

  // Seen on the DUT outputs, not yet matched
  byte_t  tx_seen [$];
  addr_t  wr_addr_seen [$];
  byte_t  wr_data_seen [$];

  dbg_top #(.ADDR_W(16)) dut0 (
    .clk      (clk),
    .rst      (rst),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .brk      (brk),
    .active   (active),
    .cpu_a    (cpu_a),
    .cpu_r_nw (cpu_r_nw),
    .cpu_dout (cpu_dout),
    .cpu_din  (cpu_din)
  );

  assign cpu_din = mem[cpu_a];  // Same cycle read

  ////////////////////////////////////////////////////////////
  // Clock, pacing and output monitor
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Only $random user, so the sequence is fixed
  always @(negedge clk)
  begin
    hold_off <= (($random(seed) & 3) == 0);  // Gap about 1 in 4
    tx_ready <= (($random(seed) & 3) != 0);
  end

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (tx_valid && tx_ready)
        tx_seen.push_back(tx_data);
      if (!cpu_r_nw)
      begin
        wr_addr_seen.push_back(cpu_a);
        wr_data_seen.push_back(cpu_dout);
        mem[cpu_a] <= cpu_dout;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Error stop and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0d ns: tx byte %h, expected %h", $time, got, exp));
  endtask

  task automatic check_write(input addr_t got_a, input byte_t got_d,
                             input addr_t exp_a, input byte_t exp_d);
    if (got_a !== exp_a || got_d !== exp_d)
      abort_run($sformatf("Fail at %0d ns: write %h <= %h, expected %h <= %h",
                          $time, got_a, got_d, exp_a, exp_d));
  endtask

  task automatic check_active(input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0d ns: active %b, expected %b", $time, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Host side actions, each starts and ends on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic send_byte(input byte_t b);
    while (hold_off)
      @(negedge clk);
    rx_data  = b;
    rx_valid = 1'b1;
    @(posedge clk);
    while (!rx_ready)
      @(posedge clk);   // Held until taken
    @(negedge clk);
    rx_valid = 1'b0;
  endtask

  task automatic expect_tx(input byte_t exp);
    byte_t got;
    if (tx_seen.size() == 0)
    begin
      while (tx_seen.size() == 0)
        @(posedge clk);
      @(negedge clk);
    end
    got = tx_seen.pop_front();
    check_byte(got, exp);
  endtask

  task automatic expect_write(input addr_t exp_a, input byte_t exp_d);
    addr_t got_a;
    byte_t got_d;
    if (wr_addr_seen.size() == 0)
    begin
      while (wr_addr_seen.size() == 0)
        @(posedge clk);
      @(negedge clk);
    end
    got_a = wr_addr_seen.pop_front();
    got_d = wr_data_seen.pop_front();
    check_write(got_a, got_d, exp_a, exp_d);
  endtask

  // Active is checked once tx has gone quiet
  task automatic expect_active(input logic exp);
    repeat (2) @(posedge clk);
    while (tx_valid)
      @(posedge clk);
    if (tx_seen.size() != 0)
      abort_run("Unexpected tx byte before an active check");
    check_active(active, exp);
    @(negedge clk);
  endtask

  task automatic pulse_brk();
    brk = 1'b1;
    @(negedge clk);
    brk = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Pattern file
  ////////////////////////////////////////////////////////////

  task automatic load_patterns();
    int    fd;
    int    c;
    int    r;
    byte_t kind;
    addr_t v1;
    byte_t v2;
    fd = $fopen("sim/dbg_patterns.txt", "r");
    if (fd == 0)
      abort_run("Cannot open the pattern file sim/dbg_patterns.txt");
    c = $fgetc(fd);
    while (c != -1)
    begin
      kind = c[7:0];
      v1   = '0;
      v2   = '0;
      if (kind == "#")
      begin
        while (c != -1 && c[7:0] != "\n")
          c = $fgetc(fd);   // Skip rest of comment
      end
      else if (kind == "s" || kind == "e" || kind == "a" || kind == "w" || kind == "b")
      begin
        if (kind != "b")
        begin
          r = $fscanf(fd, "%h", v1);
          if (r != 1)
            abort_run("Pattern line is missing its value");
        end
        if (kind == "w")
        begin
          r = $fscanf(fd, "%h", v2);
          if (r != 1)
            abort_run("Write pattern line is missing its data byte");
        end
        kind_q.push_back(kind);
        arg1_q.push_back(v1);
        arg2_q.push_back(v2);
      end
      else if (kind != " " && kind != "\n" && kind != "\r" && kind != "\t")
        abort_run("Unknown line kind in the pattern file");
      c = $fgetc(fd);
    end
    $fclose(fd);
    n_lines = kind_q.size();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst      = 1'b1;
    rx_data  = '0;
    rx_valid = 1'b0;
    tx_ready = 1'b0;
    brk      = 1'b0;
    hold_off = 1'b0;
    for (int i = 0; i < 65536; i++)
      mem[i] = byte_t'(i[7:0] ^ i[15:8]);  // Lo ^ hi address byte
    load_patterns();
    repeat (10) @(negedge clk);
    rst = 1'b0;

    for (int k = 0; k < n_lines; k++)
    begin
      case (kind_q[k])
        "s":     send_byte(arg1_q[k][7:0]);
        "e":     expect_tx(arg1_q[k][7:0]);
        "w":     expect_write(arg1_q[k], arg2_q[k]);
        "a":     expect_active(arg1_q[k][0]);
        default: pulse_brk();
      endcase
    end

    repeat (20) @(posedge clk);  // Let stray output show up
    if (tx_seen.size() != 0 || wr_addr_seen.size() != 0)
      abort_run("Extra tx byte or CPU write after the last pattern line");
    else
    begin
      $display("Verification passed");
      $finish;
    end
  end

  // 200 cycles per pattern line
  initial
  begin
    wait (n_lines > 0);
    repeat (n_lines * 200) @(posedge clk);
    abort_run("Timeout: the DUT did not get through the pattern list in time");
  end

endmodule

/* hdl/dbg_top.sv */
/*
  Debug packet engine top level.
  rx and tx are valid/ready byte streams; a byte moves on a clock edge
  with valid and ready both high. ADDR_W sets the used CPU address
  width, 9 to 16.
*/
`timescale 1ns/1ps

module dbg_top
#(
  parameter int ADDR_W = dbg_bus_pkg::ADDR_W_DEF
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  dbg_proto_pkg::byte_t rx_data,
  input  logic                 rx_valid,
  output logic                 rx_ready,
  output dbg_proto_pkg::byte_t tx_data,
  output logic                 tx_valid,
  input  logic                 tx_ready,
  input  logic                 brk,       // Break from the CPU
  output logic                 active,    // Debug session running
  output dbg_bus_pkg::addr_t   cpu_a,
  output logic                 cpu_r_nw,
  output dbg_proto_pkg::byte_t cpu_dout,
  input  dbg_proto_pkg::byte_t cpu_din
);
  import dbg_proto_pkg::*;

  logic  push;
  byte_t push_data;
  logic  full;

  dbg_cnt_if cnt_if ();
  dbg_bus_if bus_if ();

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////

  dbg_ctrl ctrl0 (
    .clk       (clk),
    .rst       (rst),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .brk       (brk),
    .active    (active),
    .cnt       (cnt_if.ctrl),
    .bus       (bus_if.ctrl),
    .push      (push),
    .push_data (push_data),
    .full      (full)
  );

  dbg_xfer_cnt cnt0 (.clk(clk), .rst(rst), .cnt(cnt_if.cnt));

  dbg_cpu_port #(.ADDR_W(ADDR_W)) port0 (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus_if.port),
    .cpu_a    (cpu_a),
    .cpu_r_nw (cpu_r_nw),
    .cpu_dout (cpu_dout),
    .cpu_din  (cpu_din)
  );

  dbg_tx_buf txb0 (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready)
  );

endmodule

/* hdl/dbg_ctrl.sv */
/*
  Packet decode FSM and sticky error code.
  Header bytes are taken as soon as they arrive. Data and answer bytes
  wait for a free tx buffer. A read costs two cycles per byte (dummy
  then sample). Unknown opcodes are dropped while disabled.
*/
`timescale 1ns/1ps

module dbg_ctrl
(
  input  logic                 clk,
  input  logic                 rst,
  input  dbg_proto_pkg::byte_t rx_data,
  input  logic                 rx_valid,
  output logic                 rx_ready,
  input  logic                 brk,        // CPU side break request
  output logic                 active,     // Holds the CPU while high
  dbg_cnt_if.ctrl              cnt,
  dbg_bus_if.ctrl              bus,
  output logic                 push,       // Byte into tx buffer
  output dbg_proto_pkg::byte_t push_data,
  input  logic                 full
);
  import dbg_proto_pkg::*;

  typedef enum logic [3:0] {
    S_DISABLED, S_DECODE,
    S_ECHO_HDR, S_ECHO_DATA,
    S_RD_HDR,   S_RD_DATA,
    S_WR_HDR,   S_WR_DATA,
    S_QUERY_ERR
  } state_t;

  state_t state_q, state_d;
  logic   phase_q, phase_d;  // Read phase, 0 dummy and 1 sample
  err_t   err_q,   err_d;
  logic   acc;               // Byte transfer on rx this cycle

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= S_DISABLED;
      phase_q <= 1'b0;
      err_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      phase_q <= phase_d;
      err_q   <= err_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // rx handshake
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (state_q)
      S_DISABLED:  rx_ready = !full && !brk;   // brk wins over a waiting opcode
      S_DECODE:    rx_ready = !full;           // Query may answer at once
      S_ECHO_HDR,
      S_RD_HDR,
      S_WR_HDR:    rx_ready = 1'b1;
      S_ECHO_DATA: rx_ready = !full && !cnt.cnt_zero;
      S_WR_DATA:   rx_ready = !cnt.cnt_zero;
      default:     rx_ready = 1'b0;            // Read and error query use no rx
    endcase
  end

  assign acc         = rx_valid && rx_ready;
  assign cnt.ld_byte = rx_data;
  assign bus.wr_byte = rx_data;   // Also the address load byte
  assign active      = (state_q != S_DISABLED);

  ////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    phase_d        = phase_q;
    err_d          = err_q;
    push           = 1'b0;
    push_data      = rx_data;  // Echo path by default
    cnt.hdr_clr    = 1'b0;
    cnt.hdr_step   = 1'b0;
    cnt.cnt_ld_lo  = 1'b0;
    cnt.cnt_ld_hi  = 1'b0;
    cnt.cnt_dec    = 1'b0;
    bus.addr_ld_lo = 1'b0;
    bus.addr_ld_hi = 1'b0;
    bus.addr_inc   = 1'b0;
    bus.wr_en      = 1'b0;

    case (state_q)
      S_DISABLED:
      begin
        if (brk)
          state_d = S_DECODE;
        else if (acc && rx_data == OP_DBG_BRK)
          state_d = S_DECODE;
        else if (acc && rx_data == OP_QUERY_DBG_BRK)
        begin
          push      = 1'b1;
          push_data = BRK_OFF;
        end
      end
      S_DECODE:
      begin
        if (acc)
        begin
          cnt.hdr_clr = 1'b1;
          case (rx_data)
            OP_ECHO:           state_d = S_ECHO_HDR;
            OP_CPU_MEM_RD:     state_d = S_RD_HDR;
            OP_CPU_MEM_WR:     state_d = S_WR_HDR;
            OP_DBG_BRK:        state_d = S_DECODE;    // Already halted
            OP_DBG_RUN:        state_d = S_DISABLED;
            OP_QUERY_ERR_CODE: state_d = S_QUERY_ERR;
            OP_QUERY_DBG_BRK:
            begin
              push      = 1'b1;
              push_data = BRK_ON;
            end
            default:           err_d[ERR_UNKNOWN_OPCODE] = 1'b1;  // Sticky until rst
          endcase
        end
      end
      S_ECHO_HDR:
      begin
        if (acc)
        begin
          cnt.hdr_step  = 1'b1;
          cnt.cnt_ld_lo = (cnt.hdr_idx == 2'd0);
          cnt.cnt_ld_hi = (cnt.hdr_idx == 2'd1);
          if (cnt.hdr_idx == 2'd1)
            state_d = S_ECHO_DATA;
        end
      end
      S_RD_HDR, S_WR_HDR:
      begin
        // ADDR_LO ADDR_HI CNT_LO CNT_HI
        if (acc)
        begin
          cnt.hdr_step   = 1'b1;
          bus.addr_ld_lo = (cnt.hdr_idx == 2'd0);
          bus.addr_ld_hi = (cnt.hdr_idx == 2'd1);
          cnt.cnt_ld_lo  = (cnt.hdr_idx == 2'd2);
          cnt.cnt_ld_hi  = (cnt.hdr_idx == 2'd3);
          if (cnt.hdr_idx == 2'd3)
          begin
            state_d = (state_q == S_RD_HDR) ? S_RD_DATA : S_WR_DATA;
            phase_d = 1'b0;
          end
        end
      end
      S_ECHO_DATA:
      begin
        if (cnt.cnt_zero)
          state_d = S_DECODE;   // Empty packet
        else if (acc)
        begin
          push        = 1'b1;
          cnt.cnt_dec = 1'b1;
          if (cnt.cnt_last)
            state_d = S_DECODE;
        end
      end
      S_RD_DATA:
      begin
        if (cnt.cnt_zero)
          state_d = S_DECODE;
        else if (!phase_q)
          phase_d = 1'b1;       // Dummy, cpu_din settles on new address
        else if (!full)
        begin
          push         = 1'b1;
          push_data    = bus.rd_byte;
          cnt.cnt_dec  = 1'b1;
          bus.addr_inc = 1'b1;
          phase_d      = 1'b0;
          if (cnt.cnt_last)
            state_d = S_DECODE;
        end
      end
      S_WR_DATA:
      begin
        if (cnt.cnt_zero)
          state_d = S_DECODE;
        else if (acc)
        begin
          bus.wr_en    = 1'b1;  // Strobe at current address
          bus.addr_inc = 1'b1;
          cnt.cnt_dec  = 1'b1;
          if (cnt.cnt_last)
            state_d = S_DECODE;
        end
      end
      S_QUERY_ERR:
      begin
        if (!full)
        begin
          push      = 1'b1;
          push_data = byte_t'(err_q);
          state_d   = S_DECODE;
        end
      end
      default: state_d = S_DISABLED;
    endcase
  end

endmodule

/* hdl/dbg_tx_buf.sv */
/*
  Single-entry output byte register, valid/ready on the tx side.
  The pusher must check full first. The byte shows on the next
  cycle and the entry frees one cycle after tx_ready takes it.
*/
`timescale 1ns/1ps

module dbg_tx_buf
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push,
  input  dbg_proto_pkg::byte_t push_data,
  output logic                 full,
  output dbg_proto_pkg::byte_t tx_data,
  output logic                 tx_valid,
  input  logic                 tx_ready
);
  import dbg_proto_pkg::*;

  logic  full_q;
  byte_t data_q;  // Payload, no reset

  always_ff @(posedge clk)
  begin
    if (rst)
      full_q <= 1'b0;
    else if (push)
      full_q <= 1'b1;
    else if (tx_ready)
      full_q <= 1'b0;    // Taken when full_q was high
  end

  always_ff @(posedge clk)
  begin
    if (push)
      data_q <= push_data;
  end

  assign full     = full_q;
  assign tx_valid = full_q;
  assign tx_data  = data_q;

endmodule

/* hdl/dbg_cpu_port.sv */
/*
  CPU address register and bus drive.
  ADDR_W from 9 to 16; address bits at ADDR_W and up stay 0.
  The write strobe is combinational from the FSM and lasts one cycle.
  cpu_din is expected to follow cpu_a in the same cycle.
*/
`timescale 1ns/1ps

module dbg_cpu_port
#(
  parameter int ADDR_W = dbg_bus_pkg::ADDR_W_DEF
)
(
  input  logic                 clk,
  input  logic                 rst,
  dbg_bus_if.port              bus,
  output dbg_bus_pkg::addr_t   cpu_a,
  output logic                 cpu_r_nw,   // Low on a write
  output dbg_proto_pkg::byte_t cpu_dout,
  input  dbg_proto_pkg::byte_t cpu_din
);
  import dbg_bus_pkg::*;

  // Ones below ADDR_W
  localparam addr_t ADDR_MASK = addr_t'((17'd1 << ADDR_W) - 17'd1);

  addr_t addr_q;
  addr_t addr_d;

  ////////////////////////////////////////////////////////////
  // Address register
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    addr_d = addr_q;
    if (bus.addr_ld_lo)
      addr_d = {addr_q[15:8], bus.wr_byte};
    else if (bus.addr_ld_hi)
      addr_d = {bus.wr_byte, addr_q[7:0]};
    else if (bus.addr_inc)
      addr_d = addr_q + 16'd1;  // Wraps at top of the masked space
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      addr_q <= '0;
    else
      addr_q <= addr_d & ADDR_MASK;
  end

  // Bus drive
  assign cpu_a       = addr_q;
  assign cpu_r_nw    = !bus.wr_en;
  assign cpu_dout    = bus.wr_byte;
  assign bus.rd_byte = cpu_din;

endmodule

/* hdl/dbg_xfer_cnt.sv */
/*
  Header byte index and 16-bit transfer byte counter.
  Count lo must be loaded before count hi. Flags come from the
  registered count, so they are valid one cycle after a load.
*/
`timescale 1ns/1ps

module dbg_xfer_cnt
(
  input  logic    clk,
  input  logic    rst,
  dbg_cnt_if.cnt  cnt
);
  import dbg_proto_pkg::*;

  hdr_idx_t idx_q;
  cnt_t     cnt_q;

  ////////////////////////////////////////////////////////////
  // Header index
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      idx_q <= '0;
    else if (cnt.hdr_clr)
      idx_q <= '0;
    else if (cnt.hdr_step)
      idx_q <= idx_q + 2'd1;   // Wraps after the 4th header byte
  end

  ////////////////////////////////////////////////////////////
  // Transfer count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      cnt_q <= '0;
    else if (cnt.cnt_ld_lo)
      cnt_q[7:0] <= cnt.ld_byte;
    else if (cnt.cnt_ld_hi)
      cnt_q[15:8] <= cnt.ld_byte;
    else if (cnt.cnt_dec)
      cnt_q <= cnt_q - 16'd1;
  end

  assign cnt.hdr_idx  = idx_q;
  assign cnt.cnt_zero = (cnt_q == 16'd0);  // Zero length packet
  assign cnt.cnt_last = (cnt_q == 16'd1);  // Final data byte pending

endmodule

/* hdl/dbg_ifs.sv */
/*
  Internal interfaces of the debug packet engine.
  dbg_cnt_if carries header index and count strobes, dbg_bus_if the
  CPU address and data strobes. Strobes are single cycle, active high.
*/
`timescale 1ns/1ps

// Control FSM to header index and transfer counter
interface dbg_cnt_if;
  import dbg_proto_pkg::*;

  logic     hdr_clr;    // Restart header at byte 0
  logic     hdr_step;   // Next header byte
  logic     cnt_ld_lo;  // Count [7:0] <= ld_byte
  logic     cnt_ld_hi;  // Count [15:8] <= ld_byte
  logic     cnt_dec;    // One data byte done
  byte_t    ld_byte;
  hdr_idx_t hdr_idx;
  logic     cnt_zero;   // Loaded count is 0
  logic     cnt_last;   // Count at 1

  modport ctrl (output hdr_clr, hdr_step, cnt_ld_lo, cnt_ld_hi, cnt_dec, ld_byte,
                input  hdr_idx, cnt_zero, cnt_last);
  modport cnt  (input  hdr_clr, hdr_step, cnt_ld_lo, cnt_ld_hi, cnt_dec, ld_byte,
                output hdr_idx, cnt_zero, cnt_last);
endinterface

// Control FSM to CPU bus port
interface dbg_bus_if;
  import dbg_proto_pkg::*;

  logic  addr_ld_lo;  // Address lo byte from wr_byte
  logic  addr_ld_hi;  // Address hi byte from wr_byte
  logic  addr_inc;
  logic  wr_en;       // Write strobe, same cycle on the bus
  byte_t wr_byte;
  byte_t rd_byte;     // cpu_din, no register

  modport ctrl (output addr_ld_lo, addr_ld_hi, addr_inc, wr_en, wr_byte,
                input  rd_byte);
  modport port (input  addr_ld_lo, addr_ld_hi, addr_inc, wr_en, wr_byte,
                output rd_byte);
endinterface

/* hdl/dbg_bus_pkg.sv */
/*
  CPU address bus definitions.
  The address type is always 16 bits wide; a narrower bus uses the
  low ADDR_W bits and keeps the bits above at 0.
*/
package dbg_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Address width and type
  ////////////////////////////////////////////////////////////

  // Full 6502 address space
  localparam int ADDR_W_DEF = 16;

  typedef logic [15:0] addr_t;  // Bus address as seen at cpu_a

endpackage

/* hdl/dbg_proto_pkg.sv */
/*
  Debug packet protocol definitions shared by the packet engine.
  Opcodes 05, 06 and 09 to 0C are not decoded and count as unknown.
  Error code bit 0 is reserved and always reads 0.
*/
package dbg_proto_pkg;

  ////////////////////////////////////////////////////////////
  // Stream and count types
  ////////////////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;     // One stream byte
  typedef logic [15:0] cnt_t;      // Transfer count, lo byte sent first
  typedef logic [1:0]  hdr_idx_t;  // Header byte position after opcode
  typedef logic [1:0]  err_t;      // Sticky error code

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // Packet layout after opcode byte:
  //   ECHO        CNT_LO CNT_HI DATA...
  //   CPU_MEM_RD  ADDR_LO ADDR_HI CNT_LO CNT_HI
  //   CPU_MEM_WR  ADDR_LO ADDR_HI CNT_LO CNT_HI DATA...
  //   all others  nothing
  localparam byte_t OP_ECHO           = 8'h00;
  localparam byte_t OP_CPU_MEM_RD     = 8'h01;
  localparam byte_t OP_CPU_MEM_WR     = 8'h02;
  localparam byte_t OP_DBG_BRK        = 8'h03;  // Halt CPU
  localparam byte_t OP_DBG_RUN        = 8'h04;  // Release CPU
  localparam byte_t OP_QUERY_DBG_BRK  = 8'h07;  // Answers 00 or 01
  localparam byte_t OP_QUERY_ERR_CODE = 8'h08;  // Answers err_t zero extended

  ////////////////////////////////////////////////////////////
  // Error code bits
  ////////////////////////////////////////////////////////////

  // Bit 0 once held a UART parity flag, now unused
  localparam int ERR_UNKNOWN_OPCODE = 1;

  // Break query answers
  localparam byte_t BRK_OFF = 8'h00;
  localparam byte_t BRK_ON  = 8'h01;

endpackage
